// File: rtl/eth_stream_pkg.sv
//--------------------
// stream data types for the link tester
// byte, length and sequence widths plus the generator FSM states
//--------------------

package eth_stream_pkg;

    // one data byte on the MAC-side stream
    typedef logic [7:0] byte_t;

    // frame length in bytes, or pause length in clock cycles
    typedef logic [15:0] frame_len_t;

    // frame sequence number
    // wraps at 256, adds to the byte index for the pattern
    typedef logic [7:0] seq_t;

    //--------------------
    // generator FSM
    //--------------------
    // idle: waiting for start and link
    // send: bytes of a frame on the stream
    // pause: gap after eof, valid held low
    typedef enum logic [1:0] {
        GEN_IDLE  = 2'd0,
        GEN_SEND  = 2'd1,
        GEN_PAUSE = 2'd2
    } gen_state_t;

endpackage

// File: rtl/eth_status_pkg.sv
//--------------------
// link status, counter and register map definitions
//--------------------

package eth_status_pkg;

    // MAC status nibble: bit 0 link, bits 2..1 speed
    typedef logic [3:0] mac_status_t;

    // speed code for 1 Gb operation
    localparam logic [1:0] SPEED_1G = 2'b10;

    // bad/errored frame counter
    typedef logic [31:0] err_cnt_t;

    // config bus
    typedef logic [3:0]  cfg_addr_t;
    typedef logic [31:0] cfg_data_t;

    // register map
    localparam cfg_addr_t REG_CTRL         = 4'd0;
    localparam cfg_addr_t REG_PKT_SIZE     = 4'd1;
    localparam cfg_addr_t REG_PAUSE_SIZE   = 4'd2;
    localparam cfg_addr_t REG_STATUS       = 4'd3;
    // counters, one address per port from here
    localparam cfg_addr_t REG_ERR_CNT_BASE = 4'd4;

    // ctrl register: clear pulse for counters and checker flags
    localparam int CTRL_CLR_BIT = 24;

    // values after reset
    localparam logic [15:0] PKT_SIZE_RST   = 16'd64;
    localparam logic [15:0] PAUSE_SIZE_RST = 16'd16;

endpackage

// File: rtl/test_ctrl_regs.sv
//--------------------
// test control/status registers
// start bits, clear pulse, frame and pause length, status readback
//--------------------
`timescale 1ns/100ps

module test_ctrl_regs
    import eth_stream_pkg::*;
    import eth_status_pkg::*;
#(
    parameter int PORT_COUNT = 4
) (
    input  logic                  aurora_usr_clk,
    input  logic                  rst_i,

    // config bus
    input  logic                  cfg_wr_i,
    input  cfg_addr_t             cfg_addr_i,
    input  cfg_data_t             cfg_wdata_i,
    output cfg_data_t             cfg_rdata_o,

    // status from the per-port blocks
    input  logic [PORT_COUNT-1:0] link_up_i,
    input  logic [PORT_COUNT-1:0] chk_err_i,
    input  err_cnt_t              err_cnt_i [PORT_COUNT],

    // control to the per-port blocks
    output logic [PORT_COUNT-1:0] start_o,
    output logic                  clr_o,
    output frame_len_t            pkt_size_o,
    output frame_len_t            pause_size_o
);

    logic wr_ctrl;

    assign wr_ctrl = cfg_wr_i && (cfg_addr_i == REG_CTRL);

    //--------------------
    // write side
    //--------------------
    always_ff @(posedge aurora_usr_clk) begin
        if (rst_i) begin
            start_o      <= '0;
            clr_o        <= 1'b0;
            pkt_size_o   <= PKT_SIZE_RST;
            pause_size_o <= PAUSE_SIZE_RST;
        end else begin
            // clear is a single-cycle pulse, never held
            clr_o <= wr_ctrl && cfg_wdata_i[CTRL_CLR_BIT];
            if (wr_ctrl) begin
                // one start bit per test instance
                start_o <= cfg_wdata_i[PORT_COUNT-1:0];
            end
            if (cfg_wr_i && (cfg_addr_i == REG_PKT_SIZE)) begin
                pkt_size_o <= cfg_wdata_i[15:0];
            end
            if (cfg_wr_i && (cfg_addr_i == REG_PAUSE_SIZE)) begin
                pause_size_o <= cfg_wdata_i[15:0];
            end
        end
    end

    //--------------------
    // read decode
    //--------------------
    always_comb begin
        cfg_rdata_o = '0;
        case (cfg_addr_i)
            REG_CTRL:       cfg_rdata_o[PORT_COUNT-1:0] = start_o;
            REG_PKT_SIZE:   cfg_rdata_o[15:0] = pkt_size_o;
            REG_PAUSE_SIZE: cfg_rdata_o[15:0] = pause_size_o;
            REG_STATUS: begin
                // link in the low byte, checker flags from bit 8
                cfg_rdata_o[PORT_COUNT-1:0]  = link_up_i;
                cfg_rdata_o[8 +: PORT_COUNT] = chk_err_i;
            end
            default: begin
                // per-port bad-frame counters
                for (int p = 0; p < PORT_COUNT; p++) begin
                    if (cfg_addr_i == cfg_addr_t'(int'(REG_ERR_CNT_BASE) + p)) begin
                        cfg_rdata_o = err_cnt_i[p];
                    end
                end
            end
        endcase
    end

endmodule

// File: rtl/frame_gen.sv
//--------------------
// test frame generator
// pattern frames of programmable length, pause between frames
//--------------------
`timescale 1ns/100ps

module frame_gen
    import eth_stream_pkg::*;
(
    input  logic       aurora_usr_clk,
    input  logic       rst_i,

    input  logic       start_i,
    input  logic       link_up_i,
    input  frame_len_t pkt_size_i,
    input  frame_len_t pause_size_i,

    // tx stream, ready is a level from the MAC side
    input  logic       tx_ready_i,
    output byte_t      tx_data_o,
    output logic       tx_valid_o,
    output logic       tx_sof_o,
    output logic       tx_eof_o
);

    gen_state_t state;
    frame_len_t byte_idx;
    frame_len_t pause_cnt;
    seq_t       seq_q;
    seq_t       launch_seq;
    logic       tx_fire;
    logic       frame_end;
    logic       pause_done;
    logic       launch;

    assign tx_fire   = tx_valid_o && tx_ready_i;
    assign frame_end = tx_fire && tx_eof_o;
    // gap finished, or no gap at all after this eof
    assign pause_done = ((state == GEN_PAUSE) && (pause_cnt <= 16'd1)) ||
                        (frame_end && (pause_size_i == '0));
    assign launch     = start_i && ((state == GEN_IDLE) || pause_done);
    // first byte of a new frame is its sequence number
    assign launch_seq = frame_end ? seq_q + 8'd1 : seq_q;

    always_ff @(posedge aurora_usr_clk) begin
        if (rst_i || !link_up_i) begin
            // link loss drops the stream at once and restarts the sequence
            state      <= GEN_IDLE;
            tx_valid_o <= 1'b0;
            tx_sof_o   <= 1'b0;
            tx_eof_o   <= 1'b0;
            seq_q      <= '0;
        end else begin
            if (frame_end) begin
                seq_q <= seq_q + 8'd1;
            end
            if (launch) begin
                state      <= GEN_SEND;
                tx_valid_o <= 1'b1;
                tx_sof_o   <= 1'b1;
                tx_eof_o   <= (pkt_size_i <= 16'd1);
                tx_data_o  <= launch_seq;
                byte_idx   <= 16'd1;
            end else begin
                case (state)
                    GEN_SEND: begin
                        // outputs hold while ready is low
                        if (frame_end) begin
                            tx_valid_o <= 1'b0;
                            tx_sof_o   <= 1'b0;
                            tx_eof_o   <= 1'b0;
                            pause_cnt  <= pause_size_i;
                            state <= (pause_size_i == '0) ? GEN_IDLE : GEN_PAUSE;
                        end else if (tx_fire) begin
                            // pattern is seq + index, so just step the byte
                            tx_data_o <= tx_data_o + 8'd1;
                            tx_sof_o  <= 1'b0;
                            tx_eof_o  <= (byte_idx == pkt_size_i - 16'd1);
                            byte_idx  <= byte_idx + 16'd1;
                        end
                    end
                    GEN_PAUSE: begin
                        // start dropped: stop here at the frame boundary
                        if (pause_cnt <= 16'd1) begin
                            state <= GEN_IDLE;
                        end else begin
                            pause_cnt <= pause_cnt - 16'd1;
                        end
                    end
                    default: begin
                        state <= GEN_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// File: rtl/frame_chk.sv
//--------------------
// received frame checker
// pattern and length compare, sticky error flag
//--------------------
`timescale 1ns/100ps

module frame_chk
    import eth_stream_pkg::*;
(
    input  logic       aurora_usr_clk,
    input  logic       rst_i,

    input  logic       link_up_i,
    input  logic       clr_i,
    input  frame_len_t pkt_size_i,

    // rx stream, no back-pressure
    input  byte_t      rx_data_i,
    input  logic       rx_valid_i,
    input  logic       rx_eof_i,

    output logic       err_o
);

    seq_t       exp_seq;
    frame_len_t beat_cnt;
    byte_t      exp_byte;
    logic       data_bad;
    logic       len_bad;

    // same rule as the generator: sequence plus beat index
    assign exp_byte = exp_seq + beat_cnt[7:0];
    assign data_bad = rx_valid_i && (rx_data_i != exp_byte);
    // beat count at eof includes the eof beat itself
    assign len_bad  = rx_valid_i && rx_eof_i && ((beat_cnt + 16'd1) != pkt_size_i);

    //--------------------
    // expected position in the stream
    //--------------------
    always_ff @(posedge aurora_usr_clk) begin
        if (rst_i || !link_up_i) begin
            exp_seq  <= '0;
            beat_cnt <= '0;
        end else if (rx_valid_i) begin
            if (rx_eof_i) begin
                // next frame, next sequence
                beat_cnt <= '0;
                exp_seq  <= exp_seq + 8'd1;
            end else begin
                beat_cnt <= beat_cnt + 16'd1;
            end
        end
    end

    //--------------------
    // sticky flag
    //--------------------
    always_ff @(posedge aurora_usr_clk) begin
        if (rst_i || clr_i) begin
            err_o <= 1'b0;
        end else if (data_bad || len_bad) begin
            // held until the next clear
            err_o <= 1'b1;
        end
    end

endmodule

// File: rtl/link_monitor.sv
//--------------------
// link qualification and bad-frame counter
//--------------------
`timescale 1ns/100ps

module link_monitor
    import eth_status_pkg::*;
(
    input  logic        aurora_usr_clk,
    input  logic        rst_i,

    input  logic        clr_i,
    input  mac_status_t mac_status_i,

    // rx frame end flags from the MAC
    input  logic        rx_valid_i,
    input  logic        rx_eof_i,
    input  logic        rx_bad_i,
    input  logic        rx_err_i,

    output logic        link_up_o,
    output err_cnt_t    err_cnt_o
);

    logic frame_flagged;

    // test only runs at 1 Gb with link up
    assign link_up_o = mac_status_i[0] && (mac_status_i[2:1] == SPEED_1G);

    // bad/err only carry meaning on the eof beat
    assign frame_flagged = rx_valid_i && rx_eof_i && (rx_bad_i || rx_err_i);

    always_ff @(posedge aurora_usr_clk) begin
        if (rst_i || clr_i) begin
            err_cnt_o <= '0;
        end else if (frame_flagged) begin
            err_cnt_o <= err_cnt_o + 32'd1;
        end
    end

endmodule

// File: rtl/eth_link_test.sv
//--------------------
// multi-port ethernet link tester, top level
// register block plus per-port generator, checker and link monitor
//--------------------
`timescale 1ns/100ps

module eth_link_test
    import eth_stream_pkg::*;
    import eth_status_pkg::*;
#(
    parameter int PORT_COUNT = 4
) (
    input  logic                    aurora_usr_clk,
    input  logic                    rst_i,

    // config bus
    input  logic                    cfg_wr_i,
    input  cfg_addr_t               cfg_addr_i,
    input  cfg_data_t               cfg_wdata_i,
    output cfg_data_t               cfg_rdata_o,

    // MAC tx side, flattened by port
    output logic [PORT_COUNT*8-1:0] mac_tx_data_o,
    output logic [PORT_COUNT-1:0]   mac_tx_valid_o,
    output logic [PORT_COUNT-1:0]   mac_tx_sof_o,
    output logic [PORT_COUNT-1:0]   mac_tx_eof_o,
    input  logic [PORT_COUNT-1:0]   mac_tx_ready_i,

    // MAC rx side
    input  logic [PORT_COUNT*8-1:0] mac_rx_data_i,
    input  logic [PORT_COUNT-1:0]   mac_rx_valid_i,
    input  logic [PORT_COUNT-1:0]   mac_rx_eof_i,
    input  logic [PORT_COUNT-1:0]   mac_rx_bad_i,
    input  logic [PORT_COUNT-1:0]   mac_rx_err_i,
    input  logic [PORT_COUNT*4-1:0] mac_status_i
);

    logic [PORT_COUNT-1:0] link_up;
    logic [PORT_COUNT-1:0] chk_err;
    logic [PORT_COUNT-1:0] test_start;
    logic                  test_clr;
    frame_len_t            pkt_size;
    frame_len_t            pause_size;
    err_cnt_t              err_cnt [PORT_COUNT];

    test_ctrl_regs #(
        .PORT_COUNT (PORT_COUNT)
    ) u_regs (
        .aurora_usr_clk (aurora_usr_clk),
        .rst_i          (rst_i),
        .cfg_wr_i       (cfg_wr_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_wdata_i    (cfg_wdata_i),
        .cfg_rdata_o    (cfg_rdata_o),
        .link_up_i      (link_up),
        .chk_err_i      (chk_err),
        .err_cnt_i      (err_cnt),
        .start_o        (test_start),
        .clr_o          (test_clr),
        .pkt_size_o     (pkt_size),
        .pause_size_o   (pause_size)
    );

    //--------------------
    // per-port test instances
    //--------------------
    for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
        // instance p sends on its partner and checks its own rx
        localparam int PARTNER = p ^ 1;

        frame_gen u_gen (
            .aurora_usr_clk (aurora_usr_clk),
            .rst_i          (rst_i),
            .start_i        (test_start[p]),
            .link_up_i      (link_up[PARTNER]),
            .pkt_size_i     (pkt_size),
            .pause_size_i   (pause_size),
            .tx_ready_i     (mac_tx_ready_i[PARTNER]),
            .tx_data_o      (mac_tx_data_o[PARTNER*8 +: 8]),
            .tx_valid_o     (mac_tx_valid_o[PARTNER]),
            .tx_sof_o       (mac_tx_sof_o[PARTNER]),
            .tx_eof_o       (mac_tx_eof_o[PARTNER])
        );

        frame_chk u_chk (
            .aurora_usr_clk (aurora_usr_clk),
            .rst_i          (rst_i),
            .link_up_i      (link_up[p]),
            .clr_i          (test_clr),
            .pkt_size_i     (pkt_size),
            .rx_data_i      (mac_rx_data_i[p*8 +: 8]),
            .rx_valid_i     (mac_rx_valid_i[p]),
            .rx_eof_i       (mac_rx_eof_i[p]),
            .err_o          (chk_err[p])
        );

        link_monitor u_mon (
            .aurora_usr_clk (aurora_usr_clk),
            .rst_i          (rst_i),
            .clr_i          (test_clr),
            .mac_status_i   (mac_status_i[p*4 +: 4]),
            .rx_valid_i     (mac_rx_valid_i[p]),
            .rx_eof_i       (mac_rx_eof_i[p]),
            .rx_bad_i       (mac_rx_bad_i[p]),
            .rx_err_i       (mac_rx_err_i[p]),
            .link_up_o      (link_up[p]),
            .err_cnt_o      (err_cnt[p])
        );
    end

endmodule

// File: testbench/eth_link_test_tb.sv
//--------------------
// testbench for the multi-port link tester
// crossed loopback per pair, register, pattern, pause and link checks
//--------------------
`timescale 1ns/100ps

module eth_link_test_tb
    import eth_stream_pkg::*;
    import eth_status_pkg::*;
();

    localparam int PORT_COUNT = 4;
    localparam int WAIT_LIMIT = 5000;
    localparam int PKT_LEN    = 20;
    localparam int PAUSE_LEN  = 7;
    // link bit set, speed code 10
    localparam logic [3:0] STATUS_1G   = 4'b0101;
    // link up but speed code 01
    localparam logic [3:0] STATUS_100M = 4'b0011;

    logic                    aurora_usr_clk;
    logic                    rst_i;
    logic                    cfg_wr_i;
    cfg_addr_t               cfg_addr_i;
    cfg_data_t               cfg_wdata_i;
    cfg_data_t               cfg_rdata_o;
    logic [PORT_COUNT*8-1:0] mac_tx_data_o;
    logic [PORT_COUNT-1:0]   mac_tx_valid_o;
    logic [PORT_COUNT-1:0]   mac_tx_sof_o;
    logic [PORT_COUNT-1:0]   mac_tx_eof_o;
    logic [PORT_COUNT-1:0]   mac_tx_ready_i;
    logic [PORT_COUNT*8-1:0] mac_rx_data_i;
    logic [PORT_COUNT-1:0]   mac_rx_valid_i;
    logic [PORT_COUNT-1:0]   mac_rx_eof_i;
    logic [PORT_COUNT-1:0]   mac_rx_bad_i;
    logic [PORT_COUNT-1:0]   mac_rx_err_i;
    logic [PORT_COUNT*4-1:0] mac_status_i;

    //--------------------
    // loopback model state
    //--------------------
    integer                seed;
    logic                  ready_random;
    logic                  gap_check_en;
    logic                  inject_err;
    int                    gap_checks;
    // per tx port tracking of the expected pattern
    logic [PORT_COUNT-1:0] track_en;
    logic [PORT_COUNT-1:0] gap_open;
    int                    tx_idx [PORT_COUNT];
    int                    tx_seq [PORT_COUNT];
    int                    frames [PORT_COUNT];
    int                    gap_len [PORT_COUNT];
    // faults still to apply, indexed by rx port
    int                    corrupt_left [PORT_COUNT];
    int                    inject_left [PORT_COUNT];

    eth_link_test #(
        .PORT_COUNT (PORT_COUNT)
    ) dut0 (
        .aurora_usr_clk (aurora_usr_clk),
        .rst_i          (rst_i),
        .cfg_wr_i       (cfg_wr_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_wdata_i    (cfg_wdata_i),
        .cfg_rdata_o    (cfg_rdata_o),
        .mac_tx_data_o  (mac_tx_data_o),
        .mac_tx_valid_o (mac_tx_valid_o),
        .mac_tx_sof_o   (mac_tx_sof_o),
        .mac_tx_eof_o   (mac_tx_eof_o),
        .mac_tx_ready_i (mac_tx_ready_i),
        .mac_rx_data_i  (mac_rx_data_i),
        .mac_rx_valid_i (mac_rx_valid_i),
        .mac_rx_eof_i   (mac_rx_eof_i),
        .mac_rx_bad_i   (mac_rx_bad_i),
        .mac_rx_err_i   (mac_rx_err_i),
        .mac_status_i   (mac_status_i)
    );

    // 4 ns clock
    initial begin
        aurora_usr_clk = 1'b0;
        forever #2 aurora_usr_clk = ~aurora_usr_clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input int got, input int exp);
        assert (got == exp) else begin
            stop_with_error($sformatf("FAIL t=%0t %s: got 0x%0h, expected 0x%0h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
        @(negedge aurora_usr_clk);
        cfg_wr_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(negedge aurora_usr_clk);
        cfg_wr_i    = 1'b0;
    endtask

    // read data is combinational, sample it mid low phase
    task automatic cfg_read(input cfg_addr_t addr, output cfg_data_t data);
        @(negedge aurora_usr_clk);
        cfg_addr_i = addr;
        #1;
        data = cfg_rdata_o;
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge aurora_usr_clk);
        end
    endtask

    // n more frames on every tracked tx port
    task automatic wait_frames(input int n);
        int  base [PORT_COUNT];
        int  cyc;
        logic done;
        for (int p = 0; p < PORT_COUNT; p++) begin
            base[p] = frames[p];
        end
        cyc  = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge aurora_usr_clk);
            cyc++;
            done = 1'b1;
            for (int p = 0; p < PORT_COUNT; p++) begin
                if (track_en[p] && frames[p] < base[p] + n) begin
                    done = 1'b0;
                end
            end
            if (!done && cyc > WAIT_LIMIT) begin
                stop_with_error("ERROR: timeout waiting for frames on all ports");
            end
        end
    endtask

    // corruption and bad/err injection all used up
    task automatic wait_faults_done();
        int cyc;
        int left;
        cyc  = 0;
        left = 1;
        while (left != 0) begin
            @(posedge aurora_usr_clk);
            cyc++;
            left = 0;
            for (int p = 0; p < PORT_COUNT; p++) begin
                left = left + corrupt_left[p] + inject_left[p];
            end
            if (left != 0 && cyc > WAIT_LIMIT) begin
                stop_with_error("ERROR: timeout waiting for injected faults to reach rx");
            end
        end
    endtask

    //--------------------
    // tx pattern tracking
    //--------------------
    // byte i of frame s is s + i, sof on byte 0, eof on the last byte
    task automatic track_tx_port(input int j, input logic fire);
        if (!track_en[j]) begin
            tx_idx[j]   = 0;
            tx_seq[j]   = 0;
            gap_open[j] = 1'b0;
        end else if (fire) begin
            check_eq($sformatf("mac_tx_sof_o[%0d]", j), int'(mac_tx_sof_o[j]),
                     (tx_idx[j] == 0) ? 1 : 0);
            check_eq($sformatf("mac_tx_eof_o[%0d]", j), int'(mac_tx_eof_o[j]),
                     (tx_idx[j] == PKT_LEN - 1) ? 1 : 0);
            check_eq($sformatf("mac_tx_data_o[%0d]", j), int'(mac_tx_data_o[j*8 +: 8]),
                     (tx_seq[j] + tx_idx[j]) % 256);
            // idle cycles since the last eof transfer
            if (tx_idx[j] == 0 && gap_open[j] && gap_check_en) begin
                check_eq($sformatf("pause before mac_tx_sof_o[%0d]", j), gap_len[j], PAUSE_LEN);
                gap_checks++;
            end
            if (tx_idx[j] == PKT_LEN - 1) begin
                tx_idx[j]   = 0;
                tx_seq[j]   = tx_seq[j] + 1;
                frames[j]   = frames[j] + 1;
                gap_open[j] = 1'b1;
                gap_len[j]  = 0;
            end else begin
                tx_idx[j] = tx_idx[j] + 1;
            end
        end else if (!mac_tx_valid_o[j]) begin
            gap_len[j] = gap_len[j] + 1;
        end
    endtask

    //--------------------
    // crossed loopback
    //--------------------
    // tx of port j lands on rx of port j ^ 1 in the same cycle
    always @(negedge aurora_usr_clk) begin : loopback
        integer                rnd;
        logic [PORT_COUNT-1:0] rdy;
        logic                  fire;
        byte_t                 d;
        int                    k;
        rnd = $random(seed);
        rdy = ready_random ? rnd[PORT_COUNT-1:0] : '1;
        mac_tx_ready_i = rdy;
        for (int j = 0; j < PORT_COUNT; j++) begin
            k    = j ^ 1;
            fire = !rst_i && mac_tx_valid_o[j] && rdy[j];
            d    = mac_tx_data_o[j*8 +: 8];
            mac_rx_bad_i[k] = 1'b0;
            mac_rx_err_i[k] = 1'b0;
            if (fire && corrupt_left[k] > 0) begin
                d = d ^ 8'h5a;
                corrupt_left[k] = corrupt_left[k] - 1;
            end
            // alternate bad and err on the chosen frame ends
            if (fire && mac_tx_eof_o[j] && inject_left[k] > 0) begin
                mac_rx_bad_i[k] = !inject_err;
                mac_rx_err_i[k] = inject_err;
                inject_err      = !inject_err;
                inject_left[k]  = inject_left[k] - 1;
            end
            mac_rx_valid_i[k]       = fire;
            mac_rx_eof_i[k]         = fire && mac_tx_eof_o[j];
            mac_rx_data_i[k*8 +: 8] = d;
            track_tx_port(j, fire);
        end
    end

    //--------------------
    // test sequence
    //--------------------
    initial begin : main
        cfg_data_t rd;
        int        cyc;
        seed           = 32'h7302;
        rst_i          = 1'b1;
        cfg_wr_i       = 1'b0;
        cfg_addr_i     = '0;
        cfg_wdata_i    = '0;
        mac_tx_ready_i = '0;
        mac_rx_data_i  = '0;
        mac_rx_valid_i = '0;
        mac_rx_eof_i   = '0;
        mac_rx_bad_i   = '0;
        mac_rx_err_i   = '0;
        // link up at 1 Gb already through reset
        mac_status_i   = {PORT_COUNT{STATUS_1G}};
        ready_random   = 1'b1;
        gap_check_en   = 1'b0;
        inject_err     = 1'b0;
        gap_checks     = 0;
        track_en       = '1;
        gap_open       = '0;
        for (int p = 0; p < PORT_COUNT; p++) begin
            tx_idx[p]       = 0;
            tx_seq[p]       = 0;
            frames[p]       = 0;
            gap_len[p]      = 0;
            corrupt_left[p] = 0;
            inject_left[p]  = 0;
        end
        repeat (5) @(negedge aurora_usr_clk);
        rst_i = 1'b0;

        // reset state
        for (int i = 0; i < 4; i++) begin
            @(negedge aurora_usr_clk);
            check_eq("mac_tx_valid_o", int'(mac_tx_valid_o), 0);
        end
        cfg_read(REG_PKT_SIZE, rd);
        check_eq("cfg_rdata_o REG_PKT_SIZE", int'(rd), 64);
        cfg_read(REG_PAUSE_SIZE, rd);
        check_eq("cfg_rdata_o REG_PAUSE_SIZE", int'(rd), 16);
        cfg_read(REG_STATUS, rd);
        check_eq("cfg_rdata_o REG_STATUS", int'(rd), 'h00f);
        for (int p = 0; p < PORT_COUNT; p++) begin
            cfg_read(cfg_addr_t'(int'(REG_ERR_CNT_BASE) + p), rd);
            check_eq($sformatf("cfg_rdata_o err_cnt[%0d]", p), int'(rd), 0);
        end

        // pattern frames with random ready
        cfg_write(REG_PKT_SIZE, PKT_LEN);
        cfg_write(REG_CTRL, 32'h0000_000f);
        wait_frames(3);
        cfg_read(REG_STATUS, rd);
        check_eq("cfg_rdata_o REG_STATUS", int'(rd), 'h00f);

        // pause length with ready held high
        ready_random = 1'b0;
        cfg_write(REG_PAUSE_SIZE, PAUSE_LEN);
        wait_frames(1);
        gap_check_en = 1'b1;
        wait_frames(3);
        assert (gap_checks >= 2 * PORT_COUNT) else begin
            stop_with_error("ERROR: too few pause gaps were measured");
        end
        @(posedge aurora_usr_clk);
        gap_check_en = 1'b0;
        ready_random = 1'b1;

        // bad-frame counter on port 2
        inject_left[2] = 3;
        wait_faults_done();
        wait_cycles(2);
        for (int p = 0; p < PORT_COUNT; p++) begin
            cfg_read(cfg_addr_t'(int'(REG_ERR_CNT_BASE) + p), rd);
            check_eq($sformatf("cfg_rdata_o err_cnt[%0d]", p), int'(rd), (p == 2) ? 3 : 0);
        end
        cfg_write(REG_CTRL, 32'h0100_000f);
        for (int p = 0; p < PORT_COUNT; p++) begin
            cfg_read(cfg_addr_t'(int'(REG_ERR_CNT_BASE) + p), rd);
            check_eq($sformatf("cfg_rdata_o err_cnt[%0d]", p), int'(rd), 0);
        end

        // checker error on port 1, sticky until clear
        @(posedge aurora_usr_clk);
        corrupt_left[1] = 1;
        wait_faults_done();
        wait_cycles(2);
        cfg_read(REG_STATUS, rd);
        check_eq("cfg_rdata_o REG_STATUS err", int'(rd[11:8]), 'h2);
        wait_cycles(50);
        cfg_read(REG_STATUS, rd);
        check_eq("cfg_rdata_o REG_STATUS err", int'(rd[11:8]), 'h2);
        cfg_write(REG_CTRL, 32'h0100_000f);
        wait_frames(3);
        cfg_read(REG_STATUS, rd);
        check_eq("cfg_rdata_o REG_STATUS err", int'(rd[11:8]), 0);

        // port 3 drops to a lower speed
        @(posedge aurora_usr_clk);
        track_en[3] = 1'b0;
        @(negedge aurora_usr_clk);
        mac_status_i[3*4 +: 4] = STATUS_100M;
        cfg_read(REG_STATUS, rd);
        check_eq("cfg_rdata_o REG_STATUS link", int'(rd[3:0]), 'h7);
        cyc = 0;
        while (mac_tx_valid_o[3]) begin
            @(negedge aurora_usr_clk);
            cyc++;
            if (cyc > 2 * (PKT_LEN + PAUSE_LEN) + 8) begin
                stop_with_error("ERROR: generator for port 3 kept sending after link loss");
            end
        end
        for (int i = 0; i < 100; i++) begin
            @(negedge aurora_usr_clk);
            check_eq("mac_tx_valid_o[3]", int'(mac_tx_valid_o[3]), 0);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: eth_link_test.f
rtl/eth_stream_pkg.sv
rtl/eth_status_pkg.sv
rtl/test_ctrl_regs.sv
rtl/frame_gen.sv
rtl/frame_chk.sv
rtl/link_monitor.sv
rtl/eth_link_test.sv
testbench/eth_link_test_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the link tester testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module eth_link_test_tb -f eth_link_test.f \
    -o eth_link_test_sim

# the log decides pass or fail
./obj_dir/eth_link_test_sim | tee sim.log

grep -q "PASS: all tests" sim.log
